/* audio_stimulus.txt */
// audio playback stimulus, one command per line: cmd address data expected, all in hex.
// cmd 1 write, 2 read and expect, 3 fill, 4 drain, 5 density; a zero cmd ends the list.
2 1 0 11b8 // reload after reset.
2 0 0 0
1 1 1234 0
2 1 0 1234
2 5 0 0 // unused address reads zero.
1 7 beef 0 // unused write has no effect.
2 1 0 1234
1 1 800 0 // long period for the fill.
1 0 7fff 0 // priming sample, popped at once.
3 0 10 10 // sixteen writes, the next one stalls at sixteen.
4 0 14 1 // drain with a short period, one interrupt.
2 0 0 0
5 0 4000 c000
5 0 c000 4000
5 0 0 8000
2 1 0 14
0 0 0 0

/* all.f */
audio_pkg.sv
sample_fifo.sv
audio_controller.sv
sample_pacer.sv
sigma_delta_dac.sv
audio_top.sv
audio_assertions.sv
audio_tb.sv

/* Makefile */
# Verilator build and run of the audio playback testbench.
VERILATOR ?= verilator
TOP ?= audio_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "PASS: all tests" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* audio_tb.sv */
module audio_tb;

	localparam int fifo_depth = 16;
	localparam int stall_cycles = 40; // how long the 17th write must stay stalled.
	localparam int max_entries = 64;

	// command codes in the first column of the stimulus file.
	localparam int cmd_write = 1;
	localparam int cmd_read = 2;
	localparam int cmd_fill = 3;
	localparam int cmd_drain = 4;
	localparam int cmd_density = 5;

	logic i_clock;
	logic i_reset;
	logic i_request;
	logic i_rw;
	logic [audio_pkg::addr_width-1:0] i_address;
	logic [audio_pkg::sample_width-1:0] i_wdata;
	logic [audio_pkg::reload_width-1:0] o_rdata;
	logic o_ready;
	logic o_interrupt;
	logic o_audio;

	logic [31:0] stim [4*max_entries]; // four words per command line.
	logic bus_busy;
	logic [31:0] stall_rdata;
	logic [audio_pkg::sample_width-1:0] stall_sample;
	int irq_count = 0;
	int budget_cycles = 0;

	audio_top #(
		.fifo_depth(fifo_depth)
	) i_audio_top (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_interrupt(o_interrupt),
		.o_audio(o_audio)
	);

	initial begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// checking.
	// ~~~~~~~~~~~~~~~~~~~~
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected)
			report_failure($sformatf("FAIL at %0t: %s is 0x%0h, expected 0x%0h",
				$time, name, actual, expected));
	endtask

	// Every interrupt pulse is counted, and it must come with the queue at half or below.
	always @(negedge i_clock) begin
		if (!i_reset && o_interrupt) begin
			irq_count <= irq_count + 1;
			if (int'(i_audio_top.fifo_count) > fifo_depth / 2)
				check_value("fifo_count at interrupt", 32'(i_audio_top.fifo_count),
					32'(fifo_depth / 2));
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// cpu access.
	// ~~~~~~~~~~~~~~~~~~~~
	task automatic cpu_access(input logic rw, input logic [3:0] addr, input logic [15:0] wdata,
			output logic [31:0] rdata);
		bus_busy = 1'b1;
		@(negedge i_clock);
		while (o_ready)
			@(negedge i_clock); // the previous access has to close first.
		i_request = 1'b1;
		i_rw = rw;
		i_address = addr;
		i_wdata = wdata;
		@(negedge i_clock);
		while (!o_ready)
			@(negedge i_clock);
		rdata = o_rdata; // valid together with ready.
		i_request = 1'b0;
		bus_busy = 1'b0;
	endtask

	task automatic fill_queue(input logic [3:0] addr, input int writes,
			input logic [31:0] expected);
		logic [31:0] rdata;
		int irq_before;
		irq_before = irq_count;
		for (int i = 1; i <= writes; i++) begin
			cpu_access(1'b1, addr, 16'($urandom), rdata);
			cpu_access(1'b0, audio_pkg::addr_samples, '0, rdata);
			check_value("queued count", rdata, 32'(i));
		end
		// One more write finds the fifo full and waits for the pacer.
		stall_sample = 16'($urandom);
		fork
			cpu_access(1'b1, addr, stall_sample, stall_rdata);
		join_none
		repeat (stall_cycles) @(negedge i_clock);
		check_value("o_ready during stall", 32'(o_ready), 32'd0);
		check_value("fifo_count during stall", 32'(i_audio_top.fifo_count), expected);
		check_value("interrupts while filling", 32'(irq_count - irq_before), 32'd0);
	endtask

	task automatic drain_queue(input logic [31:0] reload, input logic [31:0] expected_irqs);
		logic [31:0] rdata;
		int irq_before;
		int prev_count;
		int now_count;
		int cycle;
		int last_drop;
		while (bus_busy)
			@(negedge i_clock); // the stalled write lands after the first pop.
		irq_before = irq_count;
		cpu_access(1'b1, audio_pkg::addr_reload, reload[15:0], rdata);
		prev_count = int'(i_audio_top.fifo_count);
		cycle = 0;
		last_drop = -1;
		while (prev_count != 0) begin
			@(negedge i_clock);
			cycle++;
			now_count = int'(i_audio_top.fifo_count);
			if (now_count < prev_count) begin
				if (last_drop >= 0 && cycle - last_drop < int'(reload) + 1)
					check_value("pop spacing", 32'(cycle - last_drop), reload + 1);
				last_drop = cycle;
			end
			prev_count = now_count;
		end
		check_value("interrupts while draining", 32'(irq_count - irq_before), expected_irqs);
	endtask

	task automatic measure_density(input logic [15:0] sample, input logic [31:0] expected);
		logic [31:0] rdata;
		int ones;
		cpu_access(1'b1, audio_pkg::addr_samples, sample, rdata);
		rdata = 32'd1;
		while (rdata != 0)
			cpu_access(1'b0, audio_pkg::addr_samples, '0, rdata);
		repeat (4) @(negedge i_clock); // pop, latch and one dac cycle.
		ones = 0;
		repeat (65536) begin
			@(negedge i_clock);
			if (o_audio)
				ones++;
		end
		if (ones > int'(expected) + 1 || ones < int'(expected) - 1)
			check_value("o_audio ones", 32'(ones), expected);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// main sequence.
	// ~~~~~~~~~~~~~~~~~~~~
	initial begin
		int entries;
		int max_reload;
		int densities;
		logic [31:0] cmd;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] expected;
		logic [31:0] rdata;
		void'($urandom(32'h97c7_40b2));
		i_reset = 1'b1;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_address = '0;
		i_wdata = '0;
		bus_busy = 1'b0;
		for (int k = 0; k < 4 * max_entries; k++)
			stim[k] = '0;
		$readmemh("audio_stimulus.txt", stim);
		if (stim[0] == 0)
			report_failure("stimulus file audio_stimulus.txt is missing or empty");

		// The time limit grows with the commands, the longest period and the depth.
		entries = 0;
		max_reload = int'(audio_pkg::reload_reset);
		densities = 0;
		while (entries < max_entries && stim[4*entries] != 0) begin
			if ((stim[4*entries] == cmd_write && stim[4*entries+1][3:0] == audio_pkg::addr_reload)
					|| stim[4*entries] == cmd_drain)
				if (int'(stim[4*entries+2]) > max_reload)
					max_reload = int'(stim[4*entries+2]);
			if (stim[4*entries] == cmd_density)
				densities++;
			entries++;
		end
		budget_cycles = entries * 200 + densities * (65536 + 64)
			+ 2 * (fifo_depth + 2) * (max_reload + 1);

		repeat (8) @(negedge i_clock);
		i_reset = 1'b0;

		for (int n = 0; n < entries; n++) begin
			cmd = stim[4*n];
			addr = stim[4*n+1];
			data = stim[4*n+2];
			expected = stim[4*n+3];
			case (cmd)
				cmd_write: cpu_access(1'b1, addr[3:0], data[15:0], rdata);
				cmd_read: begin
					cpu_access(1'b0, addr[3:0], '0, rdata);
					check_value($sformatf("o_rdata at address %0d", addr), rdata, expected);
				end
				cmd_fill: fill_queue(addr[3:0], int'(data), expected);
				cmd_drain: drain_queue(data, expected);
				cmd_density: measure_density(data[15:0], expected);
				default: report_failure($sformatf("unknown stimulus command %0d", cmd));
			endcase
		end
		$display("PASS: all tests");
		$finish;
	end

	initial begin
		wait (budget_cycles > 0);
		repeat (budget_cycles) @(posedge i_clock);
		report_failure($sformatf("timeout: the run did not finish within %0d cycles",
			budget_cycles));
	end

endmodule

/* audio_assertions.sv */
module audio_assertions #(
	parameter int fifo_depth = 4096
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input logic i_ready,
	input logic i_interrupt,
	input logic i_push,
	input logic i_fifo_full,
	input logic [$clog2(fifo_depth + 1)-1:0] i_fifo_count
);

	logic count_above_half;

	assign count_above_half = (int'(i_fifo_count) > fifo_depth / 2);

	// ~~~~~~~~~~~~~~~~~~~~
	// cpu handshake.
	// ~~~~~~~~~~~~~~~~~~~~

	// ready only answers a request seen in the cycle before.
	ready_needs_request: assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(i_ready) |-> $past(i_request))
		else $error("o_ready rose without a request");

	// ~~~~~~~~~~~~~~~~~~~~
	// sample path.
	// ~~~~~~~~~~~~~~~~~~~~

	// A pulse comes two cycles after the count drops to half or below, and it is never
	// longer than one cycle.
	interrupt_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		i_interrupt |-> $past(count_above_half, 3) && !$past(count_above_half, 2)
			&& !$past(i_interrupt))
		else $error("o_interrupt was not a single pulse two cycles after the drop to half");

	push_not_full: assert property (@(posedge i_clock) disable iff (i_reset)
		i_push |-> !i_fifo_full) // a stalled write must wait for room.
		else $error("sample pushed into a full fifo");

endmodule

bind audio_controller audio_assertions #(
	.fifo_depth(fifo_depth)
) i_audio_assertions (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_request(i_request),
	.i_ready(o_ready),
	.i_interrupt(o_interrupt),
	.i_push(o_push),
	.i_fifo_full(i_fifo_full),
	.i_fifo_count(i_fifo_count)
);

/* audio_top.sv */
module audio_top #(
	parameter int fifo_depth = 4096
) (
	input logic i_clock,
	input logic i_reset,

	// cpu side.
	input logic i_request,
	input logic i_rw,
	input logic [audio_pkg::addr_width-1:0] i_address,
	input logic [audio_pkg::sample_width-1:0] i_wdata,
	output logic [audio_pkg::reload_width-1:0] o_rdata,
	output logic o_ready,
	output logic o_interrupt,

	output logic o_audio // one-bit stream, filter off chip.
);

	logic push;
	logic [audio_pkg::sample_width-1:0] push_data;
	logic pop;
	logic [audio_pkg::sample_width-1:0] pop_data;
	logic fifo_empty;
	logic fifo_full;
	logic [$clog2(fifo_depth + 1)-1:0] fifo_count;
	logic [audio_pkg::reload_width-1:0] reload;
	logic [audio_pkg::sample_width-1:0] current_sample;

	// ~~~~~~~~~~~~~~~~~~~~
	// cpu registers into the fifo.
	// ~~~~~~~~~~~~~~~~~~~~
	audio_controller #(
		.fifo_depth(fifo_depth)
	) i_audio_controller (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_interrupt(o_interrupt),
		.o_push(push),
		.o_push_data(push_data),
		.i_fifo_full(fifo_full),
		.i_fifo_count(fifo_count),
		.o_reload(reload)
	);

	sample_fifo #(
		.fifo_depth(fifo_depth)
	) i_sample_fifo (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_push(push),
		.i_push_data(push_data),
		.i_pop(pop),
		.o_pop_data(pop_data),
		.o_empty(fifo_empty),
		.o_full(fifo_full),
		.o_count(fifo_count)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// playback.
	// ~~~~~~~~~~~~~~~~~~~~
	sample_pacer i_sample_pacer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_reload(reload),
		.i_fifo_empty(fifo_empty),
		.o_pop(pop),
		.i_pop_data(pop_data),
		.o_sample(current_sample)
	);

	sigma_delta_dac i_sigma_delta_dac (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_sample(current_sample),
		.o_audio(o_audio)
	);

endmodule

/* sigma_delta_dac.sv */
module sigma_delta_dac (
	input logic i_clock,
	input logic i_reset,

	input logic [audio_pkg::sample_width-1:0] i_sample, // signed two's complement.
	output logic o_audio
);

	localparam int msb = audio_pkg::sample_width - 1;

	logic [audio_pkg::sample_width-1:0] offset_sample;
	logic [audio_pkg::sample_width-1:0] accumulator;
	logic [audio_pkg::sample_width:0] sum;

	// Flipping the sign bit maps -32768..32767 onto 0..65535.
	assign offset_sample = {~i_sample[msb], i_sample[msb-1:0]};

	// The carry out of the accumulator is the output bit.
	// Its density is offset_sample / 65536.
	assign sum = {1'b0, accumulator} + {1'b0, offset_sample};

	// ~~~~~~~~~~~~~~~~~~~~
	// first-order loop.
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			accumulator <= '0;
			o_audio <= 1'b0;
		end else begin
			accumulator <= sum[msb:0]; // residue is carried to the next cycle.
			o_audio <= sum[audio_pkg::sample_width];
		end
	end

endmodule

/* sample_pacer.sv */
module sample_pacer (
	input logic i_clock,
	input logic i_reset,

	input logic [audio_pkg::reload_width-1:0] i_reload,

	// fifo read side.
	input logic i_fifo_empty,
	output logic o_pop,
	input logic [audio_pkg::sample_width-1:0] i_pop_data,

	output logic [audio_pkg::sample_width-1:0] o_sample
);

	logic [audio_pkg::reload_width-1:0] period_count;
	logic pop_pending;

	// The counter parks at zero until the fifo has something to give.
	assign o_pop = (period_count == '0) && !i_fifo_empty;

	// ~~~~~~~~~~~~~~~~~~~~
	// period counter.
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			period_count <= '0;
		end else if (o_pop) begin
			period_count <= i_reload; // next pop is reload plus one cycles away.
		end else if (period_count != '0) begin
			period_count <= period_count - 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// current sample.
	// ~~~~~~~~~~~~~~~~~~~~

	// The fifo read data is registered, so the word is taken one cycle after the pop.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pop_pending <= 1'b0;
			o_sample <= '0;
		end else begin
			pop_pending <= o_pop;
			if (pop_pending)
				o_sample <= i_pop_data; // held until the next pop.
		end
	end

endmodule

/* audio_controller.sv */
module audio_controller #(
	parameter int fifo_depth = 4096
) (
	input logic i_clock,
	input logic i_reset,

	// cpu side.
	input logic i_request,
	input logic i_rw, // 1 is a write.
	input logic [audio_pkg::addr_width-1:0] i_address,
	input logic [audio_pkg::sample_width-1:0] i_wdata,
	output logic [audio_pkg::reload_width-1:0] o_rdata,
	output logic o_ready,
	output logic o_interrupt,

	// fifo and pacer side.
	output logic o_push,
	output logic [audio_pkg::sample_width-1:0] o_push_data,
	input logic i_fifo_full,
	input logic [$clog2(fifo_depth + 1)-1:0] i_fifo_count,
	output logic [audio_pkg::reload_width-1:0] o_reload
);

	localparam int count_width = $clog2(fifo_depth + 1);
	localparam logic [count_width-1:0] half_depth = count_width'(fifo_depth / 2);

	logic access_start;
	logic sample_write;
	logic can_complete;
	logic above_half;
	logic [1:0] above_history;

	// A new access is one that has not been acknowledged yet.
	assign access_start = i_request && !o_ready;
	assign sample_write = i_rw && (i_address == audio_pkg::addr_samples);

	// Only a sample write can stall, and only while the fifo has no room.
	assign can_complete = !(sample_write && i_fifo_full);

	// ~~~~~~~~~~~~~~~~~~~~
	// handshake and register writes.
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_push <= 1'b0;
			o_reload <= audio_pkg::reload_reset;
		end else begin
			o_push <= 1'b0; // push is a single-cycle pulse.
			if (access_start && can_complete) begin
				o_ready <= 1'b1;
				if (i_rw) begin
					case (i_address)
						audio_pkg::addr_samples: o_push <= 1'b1;
						audio_pkg::addr_reload:
							o_reload <= {
								{(audio_pkg::reload_width - audio_pkg::sample_width){1'b0}},
								i_wdata
							};
						default: o_reload <= o_reload; // unused addresses just complete.
					endcase
				end
			end else if (!i_request) begin
				o_ready <= 1'b0; // falls one cycle after the cpu lets go.
			end
		end
	end

	// Read data and the pushed word carry no reset.
	always_ff @(posedge i_clock) begin
		if (access_start && !i_rw) begin
			case (i_address)
				audio_pkg::addr_samples:
					o_rdata <= {
						{(audio_pkg::reload_width - count_width){1'b0}},
						i_fifo_count
					};
				audio_pkg::addr_reload: o_rdata <= o_reload;
				default: o_rdata <= '0;
			endcase
		end
		if (access_start && sample_write)
			o_push_data <= i_wdata; // reloaded every stalled cycle, same value.
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// half-full interrupt.
	// ~~~~~~~~~~~~~~~~~~~~

	// The pulse marks the queue draining down to half or below,
	// two cycles after the count that crossed.
	assign above_half = (i_fifo_count > half_depth);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			above_history <= 2'b00;
			o_interrupt <= 1'b0;
		end else begin
			above_history <= {above_history[0], above_half};
			o_interrupt <= (above_history == 2'b10); // falling edge of the above-half flag.
		end
	end

endmodule

/* sample_fifo.sv */
module sample_fifo #(
	parameter int fifo_depth = 4096
) (
	input logic i_clock,
	input logic i_reset,

	input logic i_push,
	input logic [audio_pkg::sample_width-1:0] i_push_data,
	input logic i_pop,
	output logic [audio_pkg::sample_width-1:0] o_pop_data,

	output logic o_empty,
	output logic o_full,
	output logic [$clog2(fifo_depth + 1)-1:0] o_count
);

	localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int count_width = $clog2(fifo_depth + 1); // wide enough to show a full fifo.
	localparam logic [ptr_width-1:0] last_slot = ptr_width'(fifo_depth - 1);
	localparam logic [count_width-1:0] full_count = count_width'(fifo_depth);

	logic [audio_pkg::sample_width-1:0] mem [fifo_depth];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	// Requests that would overrun or underrun the buffer are dropped here.
	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && !o_empty;

	assign o_empty = (o_count == '0);
	assign o_full = (o_count == full_count);

	// ~~~~~~~~~~~~~~~~~~~~
	// pointers and occupancy.
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			o_count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1; // depth need not be a power of two.
			if (do_pop)
				rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: o_count <= o_count + 1'b1;
				2'b01: o_count <= o_count - 1'b1;
				default: o_count <= o_count; // both or neither leaves the count alone.
			endcase
		end
	end

	// Storage and the registered read port.
	always_ff @(posedge i_clock) begin
		if (do_push)
			mem[wr_ptr] <= i_push_data;
		if (do_pop)
			o_pop_data <= mem[rd_ptr]; // valid in the cycle after the pop.
	end

endmodule

/* audio_pkg.sv */
package audio_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// data path widths.
	// ~~~~~~~~~~~~~~~~~~~~

	localparam int sample_width = 16; // signed pcm samples, write data and fifo words.
	localparam int reload_width = 32; // reload register and cpu read word.
	localparam int addr_width = 4;

	// The pacer period after reset.
	// 4536 cycles of a 200 MHz clock is close to a 44.1 kHz sample rate.
	localparam logic [reload_width-1:0] reload_reset = 32'd4536;

	// ~~~~~~~~~~~~~~~~~~~~
	// register map.
	// ~~~~~~~~~~~~~~~~~~~~

	// read gives the queued count, write pushes one sample.
	localparam logic [addr_width-1:0] addr_samples = 4'h0;

	localparam logic [addr_width-1:0] addr_reload = 4'h1; // pacer period, read and write.

	// Every other address completes at once and reads back as zero.

endpackage
